// ==== src/rv_core_pkg.sv ====
package rv_core_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////
    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register index
    typedef logic [3:0]  alu_op_t;   // alu operation select
    typedef logic [2:0]  credit_t;   // 0 .. IQ_DEPTH

    localparam int IQ_DEPTH = 4;     // instruction queue entries
    localparam int NUM_REGS = 32;

    localparam reg_idx_t ZERO_REG = 5'd0;

    //////////////////////////////////////////////////////////////////////
    // rv32i major opcodes
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // reg-reg alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 of the integer alu group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    //////////////////////////////////////////////////////////////////////
    // alu operation codes
    //////////////////////////////////////////////////////////////////////
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // lui, result is operand b

endpackage

// ==== src/issue_if.sv ====
`timescale 1ns/1ns

// decoded operation, decode -> execute
interface issue_if;
    import rv_core_pkg::*;

    logic     valid;    // one cycle per issued op
    alu_op_t  alu_op;
    xlen_t    opnd_a;
    xlen_t    opnd_b;   // rs2 value or immediate
    reg_idx_t rd;       // ZERO_REG when nothing is written
    xlen_t    pc;
    logic     illegal;

    modport decode_mp (
        output valid, alu_op, opnd_a, opnd_b, rd, pc, illegal
    );

    modport execute_mp (
        input valid, alu_op, opnd_a, opnd_b, rd, pc, illegal
    );

endinterface

// ==== src/exec_if.sv ====
`timescale 1ns/1ns

// alu result, execute -> result
interface exec_if;
    import rv_core_pkg::*;

    logic     valid;
    xlen_t    result;
    reg_idx_t rd;
    xlen_t    pc;       // pc of the op, npc is formed at commit
    logic     illegal;

    modport execute_mp (
        output valid, result, rd, pc, illegal
    );

    modport result_mp (
        input valid, result, rd, pc, illegal
    );

endinterface

// ==== src/wb_if.sv ====
`timescale 1ns/1ns

// register file read port and writeback broadcast
interface wb_if;
    import rv_core_pkg::*;

    // source reads, index from decode, data back combinationally
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_data;
    xlen_t    rs2_data;

    // high in the cycle the register file is written
    logic     wb_valid;
    reg_idx_t wb_idx;
    xlen_t    wb_data;

    modport decode_mp (
        output rs1_idx, rs2_idx,
        input  rs1_data, rs2_data,
        input  wb_valid, wb_idx, wb_data
    );

    modport result_mp (
        input  rs1_idx, rs2_idx,
        output rs1_data, rs2_data,
        output wb_valid, wb_idx, wb_data
    );

endinterface

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  rv_core_pkg::inst_t inst,
    input  rv_core_pkg::xlen_t pc,
    output logic               credit_return,
    issue_if.decode_mp         issue,
    wb_if.decode_mp            wb
);
    import rv_core_pkg::*;

    localparam int PTR_W = $clog2(IQ_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // instruction queue
    //////////////////////////////////////////////////////////////////////
    inst_t             iq_inst [IQ_DEPTH];
    xlen_t             iq_pc   [IQ_DEPTH];
    logic [PTR_W-1:0]  head_ptr;
    logic [PTR_W-1:0]  tail_ptr;
    credit_t           iq_count;

    logic              issue_fire;

    // source only sends with credit, so no full check here
    always_ff @(posedge clock) begin
        if (inst_valid) begin
            iq_inst[tail_ptr] <= inst;
            iq_pc[tail_ptr]   <= pc;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            iq_count <= '0;
        end else begin
            if (inst_valid)
                tail_ptr <= tail_ptr + 1'b1;  // depth is a power of two, wraps
            if (issue_fire)
                head_ptr <= head_ptr + 1'b1;
            iq_count <= iq_count + credit_t'(inst_valid) - credit_t'(issue_fire);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // head decode
    //////////////////////////////////////////////////////////////////////
    inst_t    head_inst;
    reg_idx_t head_rs1;
    reg_idx_t head_rs2;
    reg_idx_t dest_rd;
    alu_op_t  dec_op;
    xlen_t    dec_imm;
    logic     use_rs1;
    logic     use_rs2;
    logic     use_imm;
    logic     dec_illegal;

    // alt is inst[30], picks sub/sra; no subtract in the imm form
    function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic alt,
                                        input logic is_reg);
        alu_op_t op;
        case (funct3)
            F3_ADD_SUB: op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign head_inst = iq_inst[head_ptr];
    assign head_rs1  = head_inst[19:15];
    assign head_rs2  = head_inst[24:20];

    always_comb begin
        dec_op      = ALU_ADD;
        dec_imm     = '0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        use_imm     = 1'b0;
        dec_illegal = 1'b0;
        case (head_inst[6:0])
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                dec_op  = alu_sel(head_inst[14:12], head_inst[30], 1'b1);
            end
            OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                use_imm = 1'b1;
                dec_imm = {{20{head_inst[31]}}, head_inst[31:20]};  // shamt sits in [4:0]
                dec_op  = alu_sel(head_inst[14:12], head_inst[30], 1'b0);
            end
            OPC_LUI: begin
                use_imm = 1'b1;
                dec_imm = {head_inst[31:12], 12'b0};
                dec_op  = ALU_PASS_B;
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    assign dest_rd = dec_illegal ? ZERO_REG : head_inst[11:7];

    //////////////////////////////////////////////////////////////////////
    // scoreboard and issue
    //////////////////////////////////////////////////////////////////////
    logic [NUM_REGS-1:0] busy;
    logic                src_busy;

    assign src_busy   = (use_rs1 && busy[head_rs1]) || (use_rs2 && busy[head_rs2]);
    assign issue_fire = (iq_count != '0) && !src_busy;

    // set after clear, so a new writer of the same reg keeps its bit
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            if (wb.wb_valid)
                busy[wb.wb_idx] <= 1'b0;
            if (issue_fire && dest_rd != ZERO_REG)
                busy[dest_rd] <= 1'b1;
        end
    end

    assign wb.rs1_idx    = head_rs1;
    assign wb.rs2_idx    = head_rs2;

    assign issue.valid   = issue_fire;
    assign issue.alu_op  = dec_op;
    assign issue.opnd_a  = use_rs1 ? wb.rs1_data : '0;
    assign issue.opnd_b  = use_imm ? dec_imm : wb.rs2_data;
    assign issue.rd      = dest_rd;
    assign issue.pc      = iq_pc[head_ptr];
    assign issue.illegal = dec_illegal;

    assign credit_return = issue_fire;  // entry leaves the queue this cycle

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute (
    input  logic        clock,
    input  logic        arst_n,
    issue_if.execute_mp issue,
    exec_if.execute_mp  exec
);
    import rv_core_pkg::*;

    xlen_t      alu_out;
    logic [4:0] shamt;

    assign shamt = issue.opnd_b[4:0];  // only low five bits shift

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (issue.alu_op)
            ALU_ADD:    alu_out = issue.opnd_a + issue.opnd_b;
            ALU_SUB:    alu_out = issue.opnd_a - issue.opnd_b;
            ALU_AND:    alu_out = issue.opnd_a & issue.opnd_b;
            ALU_OR:     alu_out = issue.opnd_a | issue.opnd_b;
            ALU_XOR:    alu_out = issue.opnd_a ^ issue.opnd_b;
            ALU_SLL:    alu_out = issue.opnd_a << shamt;
            ALU_SRL:    alu_out = issue.opnd_a >> shamt;
            ALU_SRA:    alu_out = xlen_t'($signed(issue.opnd_a) >>> shamt);
            ALU_SLT: begin
                alu_out = {31'b0, $signed(issue.opnd_a) < $signed(issue.opnd_b)};
            end
            ALU_SLTU:   alu_out = {31'b0, issue.opnd_a < issue.opnd_b};
            ALU_PASS_B: alu_out = issue.opnd_b;
            default:    alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            exec.valid <= 1'b0;
        else
            exec.valid <= issue.valid;
    end

    // payload follows the op, holds when idle
    always_ff @(posedge clock) begin
        if (issue.valid) begin
            exec.result  <= alu_out;
            exec.rd      <= issue.rd;
            exec.pc      <= issue.pc;
            exec.illegal <= issue.illegal;
        end
    end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ns

module rv_result (
    input  logic                  clock,
    input  logic                  arst_n,
    exec_if.result_mp             exec,
    wb_if.result_mp               wb,
    output logic                  commit_valid,
    output rv_core_pkg::reg_idx_t commit_reg_idx,
    output rv_core_pkg::xlen_t    commit_data,
    output rv_core_pkg::xlen_t    commit_npc,
    output logic                  commit_illegal
);
    import rv_core_pkg::*;

    xlen_t rf [NUM_REGS];
    logic  wb_en;

    // nothing written for illegal ops or x0
    assign wb_en = exec.valid && !exec.illegal && (exec.rd != ZERO_REG);

    //////////////////////////////////////////////////////////////////////
    // architectural register file
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                rf[i] <= '0;
        end else if (wb_en) begin
            rf[exec.rd] <= exec.result;
        end
    end

    assign wb.rs1_data = (wb.rs1_idx == ZERO_REG) ? '0 : rf[wb.rs1_idx];
    assign wb.rs2_data = (wb.rs2_idx == ZERO_REG) ? '0 : rf[wb.rs2_idx];

    // broadcast back to the scoreboard in the write cycle
    assign wb.wb_valid = wb_en;
    assign wb.wb_idx   = exec.rd;
    assign wb.wb_data  = exec.result;

    //////////////////////////////////////////////////////////////////////
    // commit packet
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            commit_valid <= 1'b0;
        else
            commit_valid <= exec.valid;
    end

    always_ff @(posedge clock) begin
        if (exec.valid) begin
            commit_reg_idx <= wb_en ? exec.rd : ZERO_REG;
            commit_data    <= wb_en ? exec.result : '0;  // zero when no reg written
            commit_npc     <= exec.pc + xlen_t'(4);
            commit_illegal <= exec.illegal;
        end
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ns

module rv_core (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  rv_core_pkg::inst_t    inst,
    input  rv_core_pkg::xlen_t    pc,
    output logic                  credit_return,
    output logic                  commit_valid,
    output rv_core_pkg::reg_idx_t commit_reg_idx,
    output rv_core_pkg::xlen_t    commit_data,
    output rv_core_pkg::xlen_t    commit_npc,
    output logic                  commit_illegal
);

    issue_if issue_if_i ();  // decode -> execute
    exec_if  exec_if_i ();   // execute -> result
    wb_if    wb_if_i ();     // reads and writeback

    rv_decode rv_decode_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .credit_return (credit_return),
        .issue         (issue_if_i.decode_mp),
        .wb            (wb_if_i.decode_mp)
    );

    rv_execute rv_execute_i (
        .clock  (clock),
        .arst_n (arst_n),
        .issue  (issue_if_i.execute_mp),
        .exec   (exec_if_i.execute_mp)
    );

    rv_result rv_result_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .exec           (exec_if_i.result_mp),
        .wb             (wb_if_i.result_mp),
        .commit_valid   (commit_valid),
        .commit_reg_idx (commit_reg_idx),
        .commit_data    (commit_data),
        .commit_npc     (commit_npc),
        .commit_illegal (commit_illegal)
    );

endmodule

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ns

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int SEED     = 88;
    localparam int HALF_PER = 4;    // 8 ns clock
    localparam int TO_SLACK = 50;   // timeout cycles on top of 8 per entry

    logic     clock;
    logic     arst_n;
    logic     inst_valid;
    inst_t    inst;
    xlen_t    pc;
    logic     credit_return;
    logic     commit_valid;
    reg_idx_t commit_reg_idx;
    xlen_t    commit_data;
    xlen_t    commit_npc;
    logic     commit_illegal;

    // stimulus table with expected columns from the reference model
    inst_t    tbl_inst [$];
    xlen_t    tbl_pc   [$];
    reg_idx_t tbl_idx  [$];
    xlen_t    tbl_data [$];
    logic     tbl_ill  [$];

    xlen_t ref_rf [NUM_REGS];
    int    credits;
    int    sent;
    int    returns;
    int    n_done;
    int    errors;
    int    cycles;
    int    limit;

    rv_core rv_core_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .credit_return  (credit_return),
        .commit_valid   (commit_valid),
        .commit_reg_idx (commit_reg_idx),
        .commit_data    (commit_data),
        .commit_npc     (commit_npc),
        .commit_illegal (commit_illegal)
    );

    always #HALF_PER clock = ~clock;

    ////////////////////////////////////////////////////////////////////
    // instruction encoding and reference model
    ////////////////////////////////////////////////////////////////////
    function automatic inst_t r_op(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t i_op(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_t lui_op(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic add_inst(input inst_t i);
        tbl_pc.push_back(32'h0000_1000 + 32'(tbl_inst.size() * 4));
        tbl_inst.push_back(i);
        tbl_idx.push_back(ZERO_REG);
        tbl_data.push_back('0);
        tbl_ill.push_back(1'b0);
    endtask

    // rv32i semantics where alt selects sub and sra
    function automatic xlen_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic fill_expected();
        inst_t    cur;
        xlen_t    a;
        xlen_t    res;
        reg_idx_t rd;
        logic     legal;
        for (int r = 0; r < NUM_REGS; r++)
            ref_rf[r] = '0;
        for (int k = 0; k < tbl_inst.size(); k++) begin
            cur   = tbl_inst[k];
            rd    = cur[11:7];
            a     = ref_rf[cur[19:15]];
            legal = 1'b1;
            res   = '0;
            case (cur[6:0])
                OPC_OP:     res = ref_alu(cur[14:12], cur[30], a, ref_rf[cur[24:20]]);
                OPC_OP_IMM: res = ref_alu(cur[14:12], cur[30] && cur[14:12] == 3'd5, a,
                                          {{20{cur[31]}}, cur[31:20]});
                OPC_LUI:    res = {cur[31:12], 12'b0};
                default:    legal = 1'b0;
            endcase
            tbl_ill[k] = !legal;
            if (legal && rd != ZERO_REG) begin
                ref_rf[rd]  = res;
                tbl_idx[k]  = rd;
                tbl_data[k] = res;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // commit and credit monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////
    always @(negedge clock) begin : monitor
        logic ok;
        if (sent == 0) begin
            assert (!commit_valid && !credit_return) else begin
                $display("Error %0t: commit or credit active before first send", $time);
                errors++;
            end
        end
        if (credit_return) begin
            credits++;
            returns++;
            assert (credits >= 0 && credits <= IQ_DEPTH) else begin
                $display("Error %0t: source credits %0d outside 0..%0d", $time, credits,
                         IQ_DEPTH);
                errors++;
            end
        end
        if (commit_valid) begin
            assert (n_done < sent) else begin
                $display("Commit seen at %0t with no sent instruction left to commit", $time);
                errors++;
            end
        end
        if (commit_valid && n_done < sent) begin
            ok = 1'b1;
            assert (commit_reg_idx == tbl_idx[n_done]) else begin
                $display("Error %0t: test %0d reg_idx %0d, expected %0d", $time, n_done,
                         commit_reg_idx, tbl_idx[n_done]);
                ok = 1'b0;
            end
            assert (commit_data == tbl_data[n_done]) else begin
                $display("Error %0t: test %0d data %h, expected %h", $time, n_done,
                         commit_data, tbl_data[n_done]);
                ok = 1'b0;
            end
            assert (commit_illegal == tbl_ill[n_done]) else begin
                $display("Error %0t: test %0d illegal %b, expected %b", $time, n_done,
                         commit_illegal, tbl_ill[n_done]);
                ok = 1'b0;
            end
            assert (commit_npc == tbl_pc[n_done] + 32'd4) else begin
                $display("Error %0t: test %0d npc %h, expected %h", $time, n_done,
                         commit_npc, tbl_pc[n_done] + 32'd4);
                ok = 1'b0;
            end
            if (!ok)
                errors++;
            $display("test %0d pc %h inst %h: %s", n_done, tbl_pc[n_done], tbl_inst[n_done],
                     ok ? "ok" : "mismatch");
            n_done++;
        end
    end

    // run limit
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Run timed out after %0d cycles with %0d of %0d commits seen",
                 cycles, n_done, tbl_inst.size());
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        int idx;
        int gap;
        clock      = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        credits    = IQ_DEPTH;
        sent       = 0;
        returns    = 0;
        n_done     = 0;
        errors     = 0;
        limit      = 0;
        void'($urandom(SEED));

        // independent ops covering every alu function
        add_inst(lui_op(20'h80000, 1));
        add_inst(i_op(12'd100, 0, 3'd0, 2));
        add_inst(i_op(12'hFF9, 0, 3'd0, 3));           // -7
        add_inst(i_op(12'h123, 1, 3'd0, 4));
        add_inst(r_op(7'h00, 3, 2, 3'd0, 5));
        add_inst(r_op(7'h20, 2, 3, 3'd0, 6));          // sub
        add_inst(r_op(7'h00, 3, 4, 3'd7, 7));
        add_inst(r_op(7'h00, 3, 2, 3'd6, 8));
        add_inst(r_op(7'h00, 2, 4, 3'd4, 9));
        add_inst(r_op(7'h00, 2, 2, 3'd1, 10));         // shift by 100 mod 32
        add_inst(r_op(7'h00, 2, 1, 3'd5, 11));
        add_inst(r_op(7'h20, 2, 1, 3'd5, 12));         // sra
        add_inst(r_op(7'h00, 2, 3, 3'd2, 13));
        add_inst(r_op(7'h00, 2, 3, 3'd3, 14));
        add_inst(i_op(12'd5, 3, 3'd2, 15));
        add_inst(i_op(12'hFFF, 2, 3'd3, 16));
        add_inst(i_op(12'hFFF, 4, 3'd4, 17));
        add_inst(i_op(12'h700, 2, 3'd6, 18));
        add_inst(i_op(12'h0F0, 4, 3'd7, 19));
        add_inst(i_op(12'd3, 3, 3'd1, 20));
        add_inst(i_op(12'd4, 1, 3'd5, 21));
        add_inst(i_op(12'h404, 1, 3'd5, 22));          // srai by 4
        // dependent chains on rs1, rs2 and both
        add_inst(i_op(12'd1, 2, 3'd0, 23));
        add_inst(r_op(7'h00, 2, 23, 3'd0, 23));
        add_inst(r_op(7'h20, 23, 2, 3'd0, 24));
        add_inst(r_op(7'h00, 24, 24, 3'd4, 25));
        add_inst(r_op(7'h00, 24, 23, 3'd0, 26));
        // illegal jal x2 then x0 writes
        add_inst(32'h0000_016F);
        add_inst(r_op(7'h00, 0, 2, 3'd0, 30));
        add_inst(i_op(12'd55, 2, 3'd0, 0));
        add_inst(r_op(7'h00, 26, 0, 3'd0, 27));
        add_inst(r_op(7'h00, 0, 0, 3'd6, 28));
        add_inst(lui_op(20'h12345, 29));
        add_inst(i_op(12'h678, 29, 3'd0, 29));
        fill_expected();
        limit = tbl_inst.size() * 8 + TO_SLACK;

        repeat (5) @(posedge clock);
        arst_n <= 1'b1;

        // credit-obeying source with random idle gaps
        idx = 0;
        gap = $urandom_range(2, 0);
        while (idx < tbl_inst.size()) begin
            @(posedge clock);
            if (gap == 0 && credits > 0) begin
                inst_valid <= 1'b1;
                inst       <= tbl_inst[idx];
                pc         <= tbl_pc[idx];
                credits--;
                sent++;
                idx++;
                gap = $urandom_range(2, 0);
            end else begin
                inst_valid <= 1'b0;
                if (gap > 0)
                    gap--;
            end
        end
        @(posedge clock);
        inst_valid <= 1'b0;

        wait (n_done == tbl_inst.size());
        repeat (2) @(posedge clock);
        assert (returns == sent) else begin
            $display("Error %0t: %0d credit returns for %0d sends", $time, returns, sent);
            errors++;
        end
        assert (credits == IQ_DEPTH) else begin
            $display("Error %0t: source ends with %0d credits", $time, credits);
            errors++;
        end

        $display("%0d tests, %0d commits, %0d errors", tbl_inst.size(), n_done, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
src/rv_core_pkg.sv
src/issue_if.sv
src/exec_if.sv
src/wb_if.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
sim/rv_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f compile.f --top-module rv_core_tb -o rv_core_sim
	out="$$(./obj_dir/rv_core_sim)"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
